/* sim.f */
logic/piano_pkg.sv
logic/note_frame_if.sv
logic/voice_level_if.sv
logic/spi_frame_receiver.sv
logic/voice_envelope.sv
logic/voice_mixer.sv
logic/dac_serializer.sv
logic/piano_synth.sv
sim/piano_synth_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 -Wno-fatal \
    --top-module piano_synth_tb -f sim.f

./obj_dir/Vpiano_synth_tb 2>&1 | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

/* sim/piano_synth_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module piano_synth_tb;
    import piano_pkg::*;

    localparam int WAIT_LIMIT = 200;  // clock limit for each wait loop
    localparam int ENV_WORDS  = 28;   // enough dac words to cover a whole envelope

    // gain of each envelope step from rise through tail
    localparam int STEP_GAIN [16] = '{
        24, 56, 96, 127, 112, 100, 90, 80,
        70, 60, 50, 40, 30, 20, 10, 4
    };

    logic clk = 1'b0;
    logic arst_n;
    logic sck;
    logic sdi;
    logic dclk;
    logic data;
    logic load;
    logic ldac;

    int      seed = 73455;
    sample_t tone [3];   // notes of the last frame sent
    int      tone_count;

    piano_synth #(
        .STEP_CYCLES   (64),
        .BIT_CYCLES    (4),
        .STROBE_CYCLES (4)
    ) u_piano_synth (
        .clk    (clk),
        .arst_n (arst_n),
        .sck    (sck),
        .sdi    (sdi),
        .dclk   (dclk),
        .data   (data),
        .load   (load),
        .ldac   (ldac)
    );

    always #5 clk = ~clk;

    task automatic stop_run;
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_sample(input sample_t got, input sample_t exp, input string what);
        if (got !== exp)
        begin
            $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
            stop_run();
        end
    endtask

    function automatic sample_t rand_note();
        int r;
        r = $random(seed);
        if (r[7:0] == 8'd0)
            return 8'd1;  // zero would release the key
        return sample_t'(r[7:0]);
    endfunction

    // pos 0 is idle, 1 to 16 are gain steps, 17 is done
    function automatic sample_t model_word(input int pos);
        int sum;
        int mixed;
        sum = 0;
        if (pos < 1 || pos > 16)
            return '0;
        for (int i = 0; i < 3; i++)
            sum += (int'(tone[i]) * STEP_GAIN[pos-1]) >> 7;
        case (tone_count)
            0:       mixed = 0;
            1:       mixed = sum;
            2:       mixed = sum >> 1;
            default: mixed = (sum >> 2) + (sum >> 4) + (sum >> 6) + (sum >> 8);
        endcase
        return sample_t'(mixed & 255);
    endfunction

    // msb first with each sck level held for 4 clocks
    task automatic send_bits(input logic [31:0] bits_val);
        for (int i = 31; i >= 0; i--)
        begin
            @(posedge clk);
            sck <= 1'b0;
            sdi <= bits_val[i];
            repeat (4) @(posedge clk);
            sck <= 1'b1;
            repeat (3) @(posedge clk);
        end
        repeat (8) @(posedge clk);  // let the receiver publish
    endtask

    task automatic send_notes(input sample_t n0, input sample_t n1, input sample_t n2,
                              input int count);
        tone[0]    = n0;
        tone[1]    = n1;
        tone[2]    = n2;
        tone_count = count;
        send_bits({6'b0, count_t'(count), n2, n1, n0});
    endtask

    // starts after the next ldac pulse so a word is never picked up halfway
    task automatic get_dac_word(output sample_t word);
        int   cnt;
        logic prev;
        word = '0;
        cnt  = 0;
        @(negedge clk);
        while (ldac !== 1'b0)
        begin
            @(negedge clk);
            cnt++;
            if (cnt > WAIT_LIMIT)
            begin
                $display("timed out waiting for the ldac strobe");
                stop_run();
            end
        end
        for (int b = 0; b < SAMPLE_W; b++)
        begin
            cnt  = 0;
            prev = dclk;
            @(negedge clk);
            while (!(prev === 1'b0 && dclk === 1'b1))
            begin
                prev = dclk;
                @(negedge clk);
                cnt++;
                if (cnt > WAIT_LIMIT)
                begin
                    $display("timed out waiting for a dclk rising edge");
                    stop_run();
                end
            end
            word = {word[SAMPLE_W-2:0], data};
        end
        cnt = 0;
        while (load !== 1'b0)
        begin
            @(negedge clk);
            cnt++;
            if (cnt > WAIT_LIMIT)
            begin
                $display("timed out waiting for the load strobe");
                stop_run();
            end
        end
        check_level(ldac, 1'b1, "ldac while load is low");
    endtask

    task automatic expect_silence(input int words);
        sample_t w;
        for (int k = 0; k < words; k++)
        begin
            get_dac_word(w);
            check_sample(w, '0, "silent dac word");
        end
    endtask

    // words must walk the envelope forward, hit the peak and end silent
    task automatic play_and_check;
        sample_t w;
        sample_t peak;
        int      pos;
        int      p;
        bit      peak_seen;
        pos       = 0;
        peak_seen = 1'b0;
        peak      = model_word(4);
        for (int k = 0; k < ENV_WORDS; k++)
        begin
            get_dac_word(w);
            p = pos;
            while (p <= 17 && model_word(p) != w)
                p++;
            if (p > 17)
            begin
                $display("[ERROR] %0t: dac word %0d is %0d, no envelope step from %0d on gives it",
                         $time, k, w, pos);
                stop_run();
            end
            pos = p;
            if (w == peak)
                peak_seen = 1'b1;
        end
        if (!peak_seen)
        begin
            $display("[ERROR] %0t: peak word %0d never came out", $time, peak);
            stop_run();
        end
        check_sample(w, '0, "word after the envelope");
    endtask

    task automatic reset_state;
        for (int c = 0; c < 4; c++)
        begin
            @(negedge clk);
            check_level(load, 1'b1, "load in reset");
            check_level(ldac, 1'b1, "ldac in reset");
            check_level(dclk, 1'b0, "dclk in reset");
            check_level(data, 1'b0, "data in reset");
        end
        @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_level(load, 1'b1, "load after reset");
        check_level(ldac, 1'b1, "ldac after reset");
        check_level(dclk, 1'b0, "dclk after reset");
        check_level(data, 1'b0, "data after reset");
        expect_silence(2);
    endtask

    task automatic sync_hunt;
        send_notes(8'h80, 8'h00, 8'h00, 1);  // receiver still hunting so this frame is ignored
        tone[0]    = '0;
        tone_count = 0;
        expect_silence(3);
        send_bits(32'h0000_ffff);
        send_notes(rand_note(), 8'h00, 8'h00, 1);
        play_and_check();
    endtask

    task automatic mix_voices;
        send_notes(8'h00, 8'h00, 8'h00, 0);
        expect_silence(2);
        send_notes(rand_note(), rand_note(), 8'h00, 2);
        play_and_check();
        send_notes(8'h00, 8'h00, 8'h00, 0);
        expect_silence(2);
        send_notes(rand_note(), rand_note(), rand_note(), 3);
        play_and_check();
    endtask

    // notes and count from the three voice frame are still held
    task automatic done_voices;
        expect_silence(4);
    endtask

    task automatic restart_notes;
        send_notes(8'h00, 8'h00, 8'h00, 0);
        expect_silence(2);
        send_notes(rand_note(), 8'h00, rand_note(), 2);
        play_and_check();
    endtask

    initial
    begin
        arst_n = 1'b0;
        sck    = 1'b0;
        sdi    = 1'b0;
        reset_state();
        sync_hunt();
        mix_voices();
        done_voices();
        restart_notes();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* logic/piano_synth.sv */
`timescale 1ns/100ps
`default_nettype none

module piano_synth #(
    parameter int STEP_CYCLES   = 2500000,
    parameter int BIT_CYCLES    = 40,
    parameter int STROBE_CYCLES = 40
) (
    input  logic clk,
    input  logic arst_n,
    input  logic sck,
    input  logic sdi,
    output logic dclk,
    output logic data,
    output logic load,
    output logic ldac
);
    import piano_pkg::*;

    sample_t mix_sample;

    note_frame_if  u_frame_if ();
    voice_level_if u_level_if ();

    spi_frame_receiver u_rx (
        .clk    (clk),
        .arst_n (arst_n),
        .sck    (sck),
        .sdi    (sdi),
        .frame  (u_frame_if.rx)
    );

    // one envelope per note slot
    for (genvar i = 0; i < NUM_VOICES; i++)
    begin : g_voice
        voice_envelope #(
            .STEP_CYCLES (STEP_CYCLES)
        ) u_voice (
            .clk    (clk),
            .arst_n (arst_n),
            .note   (u_frame_if.note[i]),
            .level  (u_level_if.level[i]),
            .done   (u_level_if.done[i])
        );
    end

    voice_mixer u_mixer (
        .clk    (clk),
        .arst_n (arst_n),
        .frame  (u_frame_if.voice),
        .levels (u_level_if.mix),
        .sample (mix_sample)
    );

    dac_serializer #(
        .BIT_CYCLES    (BIT_CYCLES),
        .STROBE_CYCLES (STROBE_CYCLES)
    ) u_dac (
        .clk    (clk),
        .arst_n (arst_n),
        .sample (mix_sample),
        .dclk   (dclk),
        .data   (data),
        .load   (load),
        .ldac   (ldac)
    );

endmodule

`default_nettype wire

/* logic/dac_serializer.sv */
`timescale 1ns/100ps
`default_nettype none

module dac_serializer #(
    parameter int BIT_CYCLES    = 40,
    parameter int STROBE_CYCLES = 40
) (
    input  logic               clk,
    input  logic               arst_n,
    input  piano_pkg::sample_t sample,
    output logic               dclk,
    output logic               data,
    output logic               load,
    output logic               ldac
);
    import piano_pkg::*;

    localparam int MAX_CYC = (BIT_CYCLES > STROBE_CYCLES) ? BIT_CYCLES : STROBE_CYCLES;
    localparam int CNT_W   = (MAX_CYC > 1) ? $clog2(MAX_CYC) : 1;
    localparam int HALF    = BIT_CYCLES / 2;
    localparam int BIT_W   = $clog2(SAMPLE_W);

    dac_state_t       state;
    logic [CNT_W-1:0] cyc_cnt;
    logic [BIT_W-1:0] bit_cnt;
    sample_t          shreg;
    logic             period_end;

    always_comb
    begin
        case (state)
            DAC_SHIFT, DAC_GAP: period_end = (cyc_cnt == CNT_W'(BIT_CYCLES - 1));
            default:            period_end = (cyc_cnt == CNT_W'(STROBE_CYCLES - 1));
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state   <= DAC_SHIFT;
            cyc_cnt <= '0;
            bit_cnt <= '0;
        end
        else if (!period_end)
        begin
            cyc_cnt <= cyc_cnt + 1'b1;
        end
        else
        begin
            cyc_cnt <= '0;
            case (state)
                DAC_SHIFT:
                begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == BIT_W'(SAMPLE_W - 1))
                        state <= DAC_LOAD;
                end
                DAC_LOAD:  state <= DAC_LATCH;
                DAC_LATCH: state <= DAC_GAP;
                default:   state <= DAC_SHIFT;
            endcase
        end
    end

    // outputs are registered, so the whole pattern trails the counters by one clock
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            shreg <= '0;
            dclk  <= 1'b0;
            data  <= 1'b0;
            load  <= 1'b1;
            ldac  <= 1'b1;
        end
        else
        begin
            dclk <= (state == DAC_SHIFT) && (cyc_cnt >= CNT_W'(HALF));  // second half of bit
            load <= (state != DAC_LOAD);
            ldac <= (state != DAC_LATCH);
            if (state == DAC_SHIFT)
            begin
                if (cyc_cnt == '0)
                begin
                    if (bit_cnt == '0)
                        {data, shreg} <= {sample, 1'b0};  // grab a fresh sample, msb out
                    else
                        {data, shreg} <= {shreg, 1'b0};
                end
            end
            else
            begin
                data <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/voice_mixer.sv */
`timescale 1ns/100ps
`default_nettype none

module voice_mixer (
    input  logic               clk,
    input  logic               arst_n,
    note_frame_if.voice        frame,
    voice_level_if.mix         levels,
    output piano_pkg::sample_t sample
);
    import piano_pkg::*;

    localparam int SUM_W = SAMPLE_W + 2;

    count_t           done_cnt;
    count_t           active;
    logic [SUM_W-1:0] sum;
    logic [SUM_W-1:0] third;
    sample_t          mixed;

    always_comb
    begin
        done_cnt = '0;
        sum      = '0;
        for (int i = 0; i < NUM_VOICES; i++)
        begin
            done_cnt = done_cnt + count_t'(levels.done[i]);
            sum      = sum + SUM_W'(levels.level[i]);
        end
        // finished voices drop out of the struck count
        active = (frame.notes_count > done_cnt) ? frame.notes_count - done_cnt : '0;
        third  = (sum >> 2) + (sum >> 4) + (sum >> 6) + (sum >> 8);  // roughly sum / 3
        case (active)
            2'd0:    mixed = '0;
            2'd1:    mixed = sum[SAMPLE_W-1:0];
            2'd2:    mixed = sum[SAMPLE_W:1];
            default: mixed = third[SAMPLE_W-1:0];
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            sample <= '0;
        else
            sample <= mixed;
    end

endmodule

`default_nettype wire

/* logic/voice_envelope.sv */
`timescale 1ns/100ps
`default_nettype none

module voice_envelope #(
    parameter int STEP_CYCLES = 2500000
) (
    input  logic               clk,
    input  logic               arst_n,
    input  piano_pkg::sample_t note,
    output piano_pkg::sample_t level,
    output logic               done
);
    import piano_pkg::*;

    localparam int CYC_W  = (STEP_CYCLES > 1) ? $clog2(STEP_CYCLES) : 1;
    localparam int STEP_W = $clog2(ENV_STEPS);

    env_state_t                 state;
    logic [CYC_W-1:0]           cyc_cnt;
    logic [STEP_W-1:0]          step;
    gain_t                      gain;
    logic [SAMPLE_W+GAIN_W-1:0] product;

    assign gain    = ENV_GAIN[step];
    assign product = note * gain;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state   <= ENV_IDLE;
            step    <= '0;
            cyc_cnt <= '0;
        end
        else if (note == '0)
        begin
            // key released, rearm from any state
            state   <= ENV_IDLE;
            step    <= '0;
            cyc_cnt <= '0;
        end
        else
        begin
            case (state)
                ENV_IDLE:
                    state <= ENV_RUN;
                ENV_RUN:
                    if (cyc_cnt == CYC_W'(STEP_CYCLES - 1))
                    begin
                        cyc_cnt <= '0;
                        if (step == STEP_W'(ENV_STEPS - 1))
                            state <= ENV_DONE;
                        else
                            step <= step + 1'b1;
                    end
                    else
                    begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                default:
                    state <= ENV_DONE;  // stays silent until the note clears
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            level <= '0;
            done  <= 1'b0;
        end
        else
        begin
            level <= (state == ENV_RUN) ? product[GAIN_W +: SAMPLE_W] : '0;
            done  <= (state == ENV_DONE) && (note != '0);
        end
    end

endmodule

`default_nettype wire

/* logic/spi_frame_receiver.sv */
`timescale 1ns/100ps
`default_nettype none

module spi_frame_receiver (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     sck,
    input  logic     sdi,
    note_frame_if.rx frame
);
    import piano_pkg::*;

    localparam int CNT_W = $clog2(FRAME_W);

    logic [2:0]         sck_sync;  // two sync stages plus edge history
    logic [1:0]         sdi_sync;
    logic               sck_rise;
    logic [FRAME_W-1:0] shift_reg;
    logic               shifted;
    logic               frame_full;
    logic [CNT_W-1:0]   bit_cnt;
    rx_state_t          state;

    assign sck_rise = sck_sync[1] & ~sck_sync[2];

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            sck_sync  <= '0;
            sdi_sync  <= '0;
            shift_reg <= '0;
            shifted   <= 1'b0;
        end
        else
        begin
            sck_sync <= {sck_sync[1:0], sck};
            sdi_sync <= {sdi_sync[0], sdi};
            shifted  <= sck_rise;
            if (sck_rise)
                shift_reg <= {shift_reg[FRAME_W-2:0], sdi_sync[1]};  // msb first
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state      <= RX_HUNT;
            bit_cnt    <= '0;
            frame_full <= 1'b0;
        end
        else
        begin
            frame_full <= 1'b0;
            case (state)
                RX_HUNT:
                    if (shifted && shift_reg == SYNC_WORD)
                    begin
                        state   <= RX_FRAME;
                        bit_cnt <= '0;
                    end
                default:
                    if (sck_rise)
                    begin
                        bit_cnt    <= bit_cnt + 1'b1;  // wraps back to zero on the last bit
                        frame_full <= (bit_cnt == CNT_W'(FRAME_W - 1));
                    end
            endcase
        end
    end

    // split the finished frame into its fields
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            frame.note        <= '{default: '0};
            frame.notes_count <= '0;
        end
        else if (frame_full)
        begin
            for (int i = 0; i < NUM_VOICES; i++)
                frame.note[i] <= shift_reg[i*SAMPLE_W +: SAMPLE_W];
            frame.notes_count <= shift_reg[COUNT_LSB +: COUNT_W];
        end
    end

endmodule

`default_nettype wire

/* logic/voice_level_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface voice_level_if;
    import piano_pkg::*;

    sample_t level [NUM_VOICES];
    logic    done  [NUM_VOICES];  // envelope finished, voice no longer counts

    modport voice (output level, output done);
    modport mix   (input level, input done);

endinterface

`default_nettype wire

/* logic/note_frame_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface note_frame_if;
    import piano_pkg::*;

    sample_t note [NUM_VOICES];  // held until the next frame
    count_t  notes_count;

    modport rx    (output note, output notes_count);
    modport voice (input note, input notes_count);

endinterface

`default_nettype wire

/* logic/piano_pkg.sv */
`default_nettype none

package piano_pkg;

    localparam int NUM_VOICES = 3;

    localparam int SAMPLE_W = 8;
    typedef logic [SAMPLE_W-1:0] sample_t;

    localparam int COUNT_W = 2;
    typedef logic [COUNT_W-1:0] count_t;

    // frame layout: note i at [8i +: 8], count at [24 +: 2], top bits unused
    localparam int FRAME_W = 32;
    localparam logic [FRAME_W-1:0] SYNC_WORD = 32'h0000_ffff;
    localparam int COUNT_LSB = 24;

    localparam int GAIN_W = 7;
    typedef logic [GAIN_W-1:0] gain_t;

    localparam int ENV_STEPS = 16;
    localparam gain_t ENV_GAIN [ENV_STEPS] = '{
        7'd24, 7'd56, 7'd96,                   // rise
        7'd127,                                // peak
        7'd112, 7'd100, 7'd90, 7'd80, 7'd70,   // decay
        7'd60, 7'd50, 7'd40, 7'd30, 7'd20, 7'd10,
        7'd4
    };

    typedef enum logic {RX_HUNT, RX_FRAME} rx_state_t;

    typedef enum logic [1:0] {ENV_IDLE, ENV_RUN, ENV_DONE} env_state_t;

    typedef enum logic [1:0] {DAC_SHIFT, DAC_LOAD, DAC_LATCH, DAC_GAP} dac_state_t;

endpackage

`default_nettype wire
